// ==== include/mips_mem_macros.svh ====
////////////////////
// MIPS memory port widths
// Word, byte lane and lane select sizes
////////////////////
`ifndef MIPS_MEM_MACROS_SVH
`define MIPS_MEM_MACROS_SVH

// Data and address width
`define MIPS_WORD_W 32

`define MIPS_LANES 4 // Bytes per word, byteenable width

`define MIPS_LANE_BITS 2 // Low address bits that pick a lane

`endif

// ==== logic/mips_mem_pkg.sv ====
////////////////////
// MIPS memory port types
// Memory opcodes, data request and Avalon command
////////////////////
`include "mips_mem_macros.svh"

package mips_mem_pkg;

	// MIPS primary opcodes of the supported loads and stores
	typedef enum logic [5:0] {
		OP_LB  = 6'b100000,
		OP_LH  = 6'b100001,
		OP_LW  = 6'b100011,
		OP_LBU = 6'b100100,
		OP_LHU = 6'b100101,
		OP_SB  = 6'b101000,
		OP_SH  = 6'b101001,
		OP_SW  = 6'b101011
	} mem_op_e;

	// Data access from the pipeline
	typedef struct packed {
		mem_op_e                 op;
		logic [`MIPS_WORD_W-1:0] addr; // Byte address
		logic [`MIPS_WORD_W-1:0] wdata; // Store data, low aligned
	} mem_req_t;

	// Master side of the Avalon bus
	typedef struct packed {
		logic [`MIPS_WORD_W-1:0] address;
		logic                    read;
		logic                    write;
		logic [`MIPS_WORD_W-1:0] writedata;
		logic [`MIPS_LANES-1:0]  byteenable;
	} avalon_cmd_t;

endpackage

// ==== logic/byte_lane_encoder.sv ====
////////////////////
// Byte lane encoder
// Byte enables and lane placed store data
////////////////////
`timescale 1ns/1ps
`include "mips_mem_macros.svh"

module byte_lane_encoder (
	input  mips_mem_pkg::mem_req_t        req,
	output logic [`MIPS_LANES-1:0]        lane_be,
	output logic [`MIPS_WORD_W-1:0]       lane_wdata
);

	logic [`MIPS_LANE_BITS-1:0] lane;

	assign lane = req.addr[`MIPS_LANE_BITS-1:0];

	always_comb begin
		case (req.op)
			mips_mem_pkg::OP_LB,
			mips_mem_pkg::OP_LBU,
			mips_mem_pkg::OP_SB: begin
				lane_be = {{(`MIPS_LANES-1){1'b0}}, 1'b1} << lane;
			end
			mips_mem_pkg::OP_LH,
			mips_mem_pkg::OP_LHU,
			mips_mem_pkg::OP_SH: begin
				case (lane)
					2'b00:   lane_be = 4'b0011;
					2'b10:   lane_be = 4'b1100;
					default: lane_be = 4'b1111; // Odd halfword, all lanes
				endcase
			end
			default: lane_be = '1; // Word access
		endcase
	end

	// Store field moved up to its lanes, other lanes zero
	always_comb begin
		case (req.op)
			mips_mem_pkg::OP_SB: begin
				lane_wdata = {{(`MIPS_WORD_W-8){1'b0}}, req.wdata[7:0]} << {lane, 3'b000};
			end
			mips_mem_pkg::OP_SH: begin
				lane_wdata = {{(`MIPS_WORD_W-16){1'b0}}, req.wdata[15:0]} << {lane[1], 4'b0000};
			end
			default: lane_wdata = req.wdata;
		endcase
	end

endmodule

// ==== logic/load_aligner.sv ====
////////////////////
// Load aligner
// Picks and extends the loaded field
////////////////////
`timescale 1ns/1ps
`include "mips_mem_macros.svh"

module load_aligner (
	input  mips_mem_pkg::mem_req_t        req,
	input  logic [`MIPS_WORD_W-1:0]       readdata,
	output logic [`MIPS_WORD_W-1:0]       aligned_load
);

	logic [`MIPS_WORD_W-1:0] byte_word;
	logic [`MIPS_WORD_W-1:0] half_word;

	// Selected field lands in the low bits
	assign byte_word = readdata >> {req.addr[`MIPS_LANE_BITS-1:0], 3'b000};
	assign half_word = readdata >> {req.addr[`MIPS_LANE_BITS-1], 4'b0000};

	always_comb begin
		case (req.op)
			mips_mem_pkg::OP_LB: begin
				aligned_load = {{(`MIPS_WORD_W-8){byte_word[7]}}, byte_word[7:0]};
			end
			mips_mem_pkg::OP_LBU: begin
				aligned_load = {{(`MIPS_WORD_W-8){1'b0}}, byte_word[7:0]};
			end
			mips_mem_pkg::OP_LH: begin
				aligned_load = {{(`MIPS_WORD_W-16){half_word[15]}}, half_word[15:0]};
			end
			mips_mem_pkg::OP_LHU: begin
				aligned_load = {{(`MIPS_WORD_W-16){1'b0}}, half_word[15:0]};
			end
			default: aligned_load = readdata; // LW
		endcase
	end

endmodule

// ==== logic/bus_sequencer.sv ====
////////////////////
// Bus sequencer
// Shares one Avalon master between fetch and data
////////////////////
`timescale 1ns/1ps
`include "mips_mem_macros.svh"

module bus_sequencer (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          fetch_req,
	input  logic [`MIPS_WORD_W-1:0]       fetch_pc,
	input  logic                          data_req,
	input  mips_mem_pkg::mem_req_t        data_cmd,
	input  logic                          waitrequest,
	input  logic [`MIPS_WORD_W-1:0]       readdata,
	input  logic [`MIPS_LANES-1:0]        lane_be,
	input  logic [`MIPS_WORD_W-1:0]       lane_wdata,
	input  logic [`MIPS_WORD_W-1:0]       aligned_load,
	output mips_mem_pkg::avalon_cmd_t     cmd,
	output mips_mem_pkg::mem_req_t        cur_req,
	output logic                          instr_valid,
	output logic [`MIPS_WORD_W-1:0]       instr,
	output logic                          load_valid,
	output logic [`MIPS_WORD_W-1:0]       load_data,
	output logic                          store_done
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FETCH,
		ST_DATA
	} state_e;

	state_e                  state;
	logic                    fetch_wait; // Accepted, not yet on the bus
	logic                    data_wait;
	logic [`MIPS_WORD_W-1:0] fetch_pc_q;
	mips_mem_pkg::mem_req_t  data_q;

	logic                    done;
	logic                    can_issue;
	logic                    want_fetch;
	logic                    want_data;
	logic                    issue_fetch;
	logic                    issue_data;
	logic                    is_store;
	logic [`MIPS_WORD_W-1:0] pc_next;

	assign done      = (state != ST_IDLE) && !waitrequest;
	assign can_issue = (state == ST_IDLE) || done;
	assign want_data  = data_wait || data_req;
	assign want_fetch = fetch_wait || fetch_req;

	// Data first when both are waiting
	assign issue_data  = can_issue && want_data;
	assign issue_fetch = can_issue && !want_data && want_fetch;

	assign pc_next = fetch_wait ? fetch_pc_q : fetch_pc;

	// Held request until its transfer completes, else the incoming one
	assign cur_req = (data_wait || state == ST_DATA) ? data_q : data_cmd;

	assign is_store = (cur_req.op == mips_mem_pkg::OP_SB) ||
		(cur_req.op == mips_mem_pkg::OP_SH) ||
		(cur_req.op == mips_mem_pkg::OP_SW);

	always_ff @(posedge clk) begin
		if (fetch_req) begin
			fetch_pc_q <= fetch_pc;
		end
		if (data_req) begin
			data_q <= data_cmd;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= ST_IDLE;
			fetch_wait <= 1'b0;
			data_wait  <= 1'b0;
			cmd        <= '0;
		end else begin
			fetch_wait <= want_fetch && !issue_fetch;
			data_wait  <= want_data && !issue_data;
			if (issue_data) begin
				state          <= ST_DATA;
				cmd.address    <= {cur_req.addr[`MIPS_WORD_W-1:`MIPS_LANE_BITS],
					{`MIPS_LANE_BITS{1'b0}}};
				cmd.read       <= !is_store;
				cmd.write      <= is_store;
				cmd.writedata  <= lane_wdata;
				cmd.byteenable <= lane_be;
			end else if (issue_fetch) begin
				state          <= ST_FETCH;
				cmd.address    <= {pc_next[`MIPS_WORD_W-1:`MIPS_LANE_BITS],
					{`MIPS_LANE_BITS{1'b0}}};
				cmd.read       <= 1'b1;
				cmd.write      <= 1'b0;
				cmd.writedata  <= '0;
				cmd.byteenable <= '1; // Whole instruction word
			end else if (done) begin
				state     <= ST_IDLE;
				cmd.read  <= 1'b0;
				cmd.write <= 1'b0;
			end
		end
	end

	// Completion strobes, one cycle after the finishing edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			instr_valid <= 1'b0;
			load_valid  <= 1'b0;
			store_done  <= 1'b0;
		end else begin
			instr_valid <= done && (state == ST_FETCH);
			load_valid  <= done && (state == ST_DATA) && !cmd.write;
			store_done  <= done && (state == ST_DATA) && cmd.write;
		end
	end

	always_ff @(posedge clk) begin
		if (done && state == ST_FETCH) begin
			instr <= readdata;
		end
		if (done && state == ST_DATA && !cmd.write) begin
			load_data <= aligned_load;
		end
	end

endmodule

// ==== logic/mips_mem_port.sv ====
////////////////////
// MIPS memory port top
// Avalon master for fetch and data
////////////////////
`timescale 1ns/1ps
`include "mips_mem_macros.svh"

module mips_mem_port (
	input  logic                          clk,
	input  logic                          rst_n,

	input  logic                          fetch_req,
	input  logic [`MIPS_WORD_W-1:0]       fetch_pc,
	input  logic                          data_req,
	input  mips_mem_pkg::mem_req_t        data_cmd,
	output logic                          instr_valid,
	output logic [`MIPS_WORD_W-1:0]       instr,
	output logic                          load_valid,
	output logic [`MIPS_WORD_W-1:0]       load_data,
	output logic                          store_done,

	output logic [`MIPS_WORD_W-1:0]       address,
	output logic                          read,
	output logic                          write,
	output logic [`MIPS_WORD_W-1:0]       writedata,
	output logic [`MIPS_LANES-1:0]        byteenable,
	input  logic                          waitrequest,
	input  logic [`MIPS_WORD_W-1:0]       readdata
);

	mips_mem_pkg::avalon_cmd_t cmd;
	mips_mem_pkg::mem_req_t    cur_req;
	logic [`MIPS_LANES-1:0]    lane_be;
	logic [`MIPS_WORD_W-1:0]   lane_wdata;
	logic [`MIPS_WORD_W-1:0]   aligned_load;

	bus_sequencer u_seq (
		.clk          (clk),
		.rst_n        (rst_n),
		.fetch_req    (fetch_req),
		.fetch_pc     (fetch_pc),
		.data_req     (data_req),
		.data_cmd     (data_cmd),
		.waitrequest  (waitrequest),
		.readdata     (readdata),
		.lane_be      (lane_be),
		.lane_wdata   (lane_wdata),
		.aligned_load (aligned_load),
		.cmd          (cmd),
		.cur_req      (cur_req),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.load_valid   (load_valid),
		.load_data    (load_data),
		.store_done   (store_done)
	);

	byte_lane_encoder u_enc (
		.req        (cur_req),
		.lane_be    (lane_be),
		.lane_wdata (lane_wdata)
	);

	load_aligner u_align (
		.req          (cur_req),
		.readdata     (readdata),
		.aligned_load (aligned_load)
	);

	assign address    = cmd.address;
	assign read       = cmd.read;
	assign write      = cmd.write;
	assign writedata  = cmd.writedata;
	assign byteenable = cmd.byteenable;

endmodule

// ==== bench/mips_mem_port_chk.sv ====
////////////////////
// Avalon master protocol checks
////////////////////
`timescale 1ns/1ps
`include "mips_mem_macros.svh"

module mips_mem_port_chk (
	input logic                    clk,
	input logic                    rst_n,
	input logic [`MIPS_WORD_W-1:0] address,
	input logic                    read,
	input logic                    write,
	input logic [`MIPS_WORD_W-1:0] writedata,
	input logic [`MIPS_LANES-1:0]  byteenable,
	input logic                    waitrequest
);

	a_one_dir: assert property (@(posedge clk) disable iff (!rst_n) !(read && write))
		else $error("read and write high together");

	a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		address[`MIPS_LANE_BITS-1:0] == '0)
		else $error("address low bits not zero");

	// Command frozen under waitrequest
	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(read || write) && waitrequest |=> $stable(address) && $stable(read) &&
		$stable(write) && $stable(writedata) && $stable(byteenable))
		else $error("command changed during waitrequest");

	a_be: assert property (@(posedge clk) disable iff (!rst_n) write |-> byteenable != '0)
		else $error("write with no byte enabled");

endmodule

bind mips_mem_port mips_mem_port_chk u_chk (.*);

// ==== bench/mips_mem_port_tb.sv ====
////////////////////
// MIPS memory port testbench
// Random fetches and loads/stores against a model
////////////////////
`timescale 1ns/1ps
`include "mips_mem_macros.svh"

module mips_mem_port_tb;

	localparam int DEPTH = 64;
	localparam int RUN_CYCLES = 800;
	localparam int DRAIN_LIMIT = 200;

	logic clk = 1'b0;
	logic rst_n;
	logic fetch_req, data_req, waitrequest;
	logic [`MIPS_WORD_W-1:0] fetch_pc, instr, load_data, address, writedata, readdata;
	mips_mem_pkg::mem_req_t data_cmd;
	logic instr_valid, load_valid, store_done, read, write;
	logic [`MIPS_LANES-1:0] byteenable;

	logic [`MIPS_WORD_W-1:0] mem [DEPTH];
	logic [`MIPS_WORD_W-1:0] model [DEPTH];
	logic [15:0] lfsr = 16'd51004;
	int errors = 0;
	int checks = 0;
	logic fetch_out = 0, data_out = 0;
	logic [`MIPS_WORD_W-1:0] pend_pc;
	mips_mem_pkg::mem_req_t pend;
	logic prev_rd = 0, prev_wr = 0, prio_stage = 0;

	mips_mem_port dut (.*);

	always #20 clk = ~clk;

	assign readdata = mem[address[7:2]];

	always @(posedge clk) begin
		if (write && !waitrequest) begin
			for (int i = 0; i < `MIPS_LANES; i++) begin
				if (byteenable[i]) mem[address[7:2]][8*i +: 8] <= writedata[8*i +: 8];
			end
		end
	end

	// Galois LFSR, one step per bit
	function automatic logic [31:0] rnd(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic mips_mem_pkg::mem_op_e pick_op(input logic [2:0] k);
		case (k)
			3'd0: return mips_mem_pkg::OP_LB;
			3'd1: return mips_mem_pkg::OP_LBU;
			3'd2: return mips_mem_pkg::OP_LH;
			3'd3: return mips_mem_pkg::OP_LHU;
			3'd4: return mips_mem_pkg::OP_LW;
			3'd5: return mips_mem_pkg::OP_SB;
			3'd6: return mips_mem_pkg::OP_SH;
			default: return mips_mem_pkg::OP_SW;
		endcase
	endfunction

	function automatic logic is_store_op(input mips_mem_pkg::mem_op_e op);
		return op == mips_mem_pkg::OP_SB || op == mips_mem_pkg::OP_SH ||
			op == mips_mem_pkg::OP_SW;
	endfunction

	function automatic logic [3:0] lanes_of(input mips_mem_pkg::mem_op_e op, input logic [1:0] a);
		case (op)
			mips_mem_pkg::OP_SB, mips_mem_pkg::OP_LB, mips_mem_pkg::OP_LBU: return 4'b0001 << a;
			mips_mem_pkg::OP_SH, mips_mem_pkg::OP_LH, mips_mem_pkg::OP_LHU:
				return a[1] ? 4'b1100 : 4'b0011;
			default: return 4'b1111;
		endcase
	endfunction

	// Store bytes placed lane by lane
	function automatic logic [31:0] lane_data(input mips_mem_pkg::mem_req_t r);
		logic [3:0] be;
		logic [31:0] w;
		be = lanes_of(r.op, r.addr[1:0]);
		w = '0;
		for (int i = 0; i < 4; i++) begin
			if (be[i] && r.op == mips_mem_pkg::OP_SB) w[8*i +: 8] = r.wdata[7:0];
			else if (be[i] && r.op == mips_mem_pkg::OP_SH) w[8*i +: 8] = r.wdata[8*(i%2) +: 8];
			else if (be[i]) w[8*i +: 8] = r.wdata[8*i +: 8];
		end
		return w;
	endfunction

	function automatic logic [31:0] load_expect(input mips_mem_pkg::mem_req_t r,
		input logic [31:0] word);
		logic [7:0] b;
		logic [15:0] h;
		b = word[8*r.addr[1:0] +: 8];
		h = word[16*r.addr[1] +: 16];
		case (r.op)
			mips_mem_pkg::OP_LB: return {{24{b[7]}}, b};
			mips_mem_pkg::OP_LBU: return {24'd0, b};
			mips_mem_pkg::OP_LH: return {{16{h[15]}}, h};
			mips_mem_pkg::OP_LHU: return {16'd0, h};
			default: return word;
		endcase
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("error %s expected %h actual %h", name, exp, act);
		end
	endtask

	// Bus and result monitor, sampled mid cycle
	always @(negedge clk) begin
		logic [3:0] st_be;
		logic [31:0] st_word;
		if (!rst_n) begin
			check_val("reset", 32'd0, {27'd0, read, write, instr_valid, load_valid, store_done});
		end else begin
			check_val("read_strobe", {31'd0, prev_rd}, {31'd0, instr_valid | load_valid});
			check_val("store_strobe", {31'd0, prev_wr}, {31'd0, store_done});
			if (instr_valid) begin
				check_val("fetch", model[pend_pc[7:2]], instr);
				fetch_out = 0;
			end
			if (load_valid) begin
				check_val("load", load_expect(pend, model[pend.addr[7:2]]), load_data);
				data_out = 0;
			end
			if (store_done) begin
				st_be = lanes_of(pend.op, pend.addr[1:0]);
				st_word = lane_data(pend);
				for (int i = 0; i < 4; i++) begin
					if (st_be[i]) model[pend.addr[7:2]][8*i +: 8] = st_word[8*i +: 8];
				end
				data_out = 0;
			end
			if (write && !waitrequest) begin
				check_val("store_be", {28'd0, lanes_of(pend.op, pend.addr[1:0])},
					{28'd0, byteenable});
				check_val("store_wdata", lane_data(pend), writedata);
			end
			if (prio_stage) begin
				check_val("priority_addr", {pend.addr[31:2], 2'b00}, address);
				check_val("priority_dir", {30'd0, !is_store_op(pend.op), is_store_op(pend.op)},
					{30'd0, read, write});
			end
			// Joint request on an idle port, data must win next cycle
			prio_stage = fetch_req && data_req;
			if (fetch_req) fetch_out = 1;
			if (data_req) data_out = 1;
			prev_rd = read && !waitrequest;
			prev_wr = write && !waitrequest;
		end
	end

	initial begin
		int wait_cnt;
		rst_n = 0;
		fetch_req = 0;
		data_req = 0;
		waitrequest = 0;
		fetch_pc = '0;
		data_cmd = '0;
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = (i * 32'h9E3779B1) ^ {i[7:0], ~i[7:0], i[7:0], ~i[7:0]};
			model[i] = mem[i];
		end
		repeat (8) @(posedge clk);
		#2 rst_n = 1;
		for (int c = 0; c < RUN_CYCLES; c++) begin
			@(posedge clk);
			#2;
			fetch_req = 0;
			data_req = 0;
			waitrequest = (rnd(2) == 32'd3);
			if (!fetch_out && rnd(1)) begin
				fetch_pc = {24'd0, 6'(rnd(6)), 2'b00};
				pend_pc = fetch_pc;
				fetch_req = 1;
			end
			if (!data_out && rnd(1)) begin
				data_cmd.op = pick_op(3'(rnd(3)));
				data_cmd.addr = {24'd0, 6'(rnd(6)), 2'b00};
				if (lanes_of(data_cmd.op, 2'b00) == 4'b0001) data_cmd.addr[1:0] = 2'(rnd(2));
				else if (lanes_of(data_cmd.op, 2'b00) == 4'b0011) data_cmd.addr[1] = 1'(rnd(1));
				data_cmd.wdata = rnd(32);
				pend = data_cmd;
				data_req = 1;
			end
		end
		@(posedge clk);
		#2;
		fetch_req = 0;
		data_req = 0;
		waitrequest = 0;
		wait_cnt = 0;
		while ((fetch_out || data_out) && wait_cnt < DRAIN_LIMIT) begin
			@(posedge clk);
			wait_cnt++;
		end
		if (fetch_out || data_out) begin
			errors++;
			$display("timeout while waiting for outstanding requests to complete");
		end
		repeat (2) @(posedge clk);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== mips_mem_port.f ====
+incdir+include
logic/mips_mem_pkg.sv
logic/byte_lane_encoder.sv
logic/load_aligner.sv
logic/bus_sequencer.sv
logic/mips_mem_port.sv
bench/mips_mem_port_chk.sv
bench/mips_mem_port_tb.sv

// ==== Makefile ====
SIM    = verilator
FLAGS  = --binary --timing --assert
TOP    = mips_mem_port_tb
FLIST  = mips_mem_port.f
BIN    = obj_dir/V$(TOP)
LOG    = sim.log
SRCS   = $(shell grep -v '^+' $(FLIST)) include/mips_mem_macros.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
